// ==== Makefile ====
# Verilator build and run of the ROM subsystem testbench

VERILATOR ?= verilator
TOP       ?= rom_subsys_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
hdl/rom_pkg.sv
hdl/rom_prog_loader.sv
hdl/rom_read_slot.sv
hdl/rom_bank_arbiter.sv
hdl/rom_subsys_top.sv
verification/rom_subsys_sva.sv
verification/rom_subsys_tb.sv

// ==== hdl/rom_bank_arbiter.sv ====
/*
 * Bank 1 read arbiter
 * Round-robin ownership of the read-only bank between two slots;
 * no new grant is given while a download is running
 */
`default_nettype none

module rom_bank_arbiter (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         downloading,
    input  wire rom_pkg::bank_req_t           req_a,
    input  wire rom_pkg::bank_req_t           req_b,
    output logic                              ack_a,
    output logic                              ack_b,
    output logic                              rdy_a,
    output logic                              rdy_b,
    output logic [rom_pkg::addr_w-1:0]        ba_addr,
    output logic                              ba_rd,
    input  wire logic                         ba_ack,
    input  wire logic                         ba_rdy
);
    import rom_pkg::*;

    typedef enum logic {
        st_idle,
        st_busy
    } arb_state_t;

    arb_state_t state;
    logic       owner;      // 0 for slot a, 1 for slot b
    logic       last;       // slot served most recently
    logic       next_owner;
    bank_req_t  cur;

    // Round-robin pick, only one requester wins outright
    always_comb begin
        if (req_a.rd && req_b.rd) begin
            next_owner = ~last;
        end else begin
            next_owner = req_b.rd;
        end
    end

    assign cur = owner ? req_b : req_a;

    // Bank port follows the owner while busy
    assign ba_addr = cur.addr;
    assign ba_rd   = (state == st_busy) & cur.rd;

    // Bank replies go back to the owner only
    assign ack_a = (state == st_busy) & ~owner & ba_ack;
    assign ack_b = (state == st_busy) & owner & ba_ack;
    assign rdy_a = (state == st_busy) & ~owner & ba_rdy;
    assign rdy_b = (state == st_busy) & owner & ba_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            owner <= 1'b0;
            last  <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (!downloading && (req_a.rd || req_b.rd)) begin
                        owner <= next_owner;
                        state <= st_busy;
                    end
                end
                default: begin
                    // Release once the data has been delivered
                    if (ba_rdy) begin
                        last  <= owner;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rom_pkg.sv ====
/*
 * ROM subsystem package
 * Download region map, SDRAM and client widths, and the structs
 * shared by the loader, the read slots and the bank arbiter
 */
`default_nettype none

package rom_pkg;

    // SDRAM bank port
    localparam int addr_w = 22;
    localparam int data_w = 16;

    // ioctl download port, byte addressed
    localparam int ioctl_aw = 25;

    // Download layout in bytes: main ROM, then sound, then graphics
    localparam logic [ioctl_aw-1:0] snd_start = 25'h004_0000;
    localparam logic [ioctl_aw-1:0] gfx_start = 25'h006_0000;
    localparam logic [ioctl_aw-1:0] rom_end   = 25'h046_0000;

    // Bank 1 layout in words, sound sits at word 0
    localparam logic [addr_w-1:0] gfx_base = 22'h01_0000;

    // Client address widths
    localparam int snd_aw = 19;  // bytes
    localparam int gfx_aw = 20;  // 32-bit words

    // One SDRAM programming write
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [1:0]        mask;  // active low byte enable
        logic [1:0]        ba;
    } prog_word_t;

    // Read request from a slot to the bank arbiter
    typedef struct packed {
        logic              rd;
        logic [addr_w-1:0] addr;
    } bank_req_t;

endpackage

`default_nettype wire

// ==== hdl/rom_prog_loader.sv ====
/*
 * ROM download packer
 * Maps each ioctl byte onto a bank and word address from the region
 * map and issues one masked SDRAM programming write per byte
 */
`default_nettype none

module rom_prog_loader (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      downloading,
    input  wire logic                      ioctl_wr,
    input  wire logic [rom_pkg::ioctl_aw-1:0] ioctl_addr,
    input  wire logic [7:0]                ioctl_data,
    output rom_pkg::prog_word_t            prog,
    output logic                           prog_we,
    output logic                           dwnld_busy
);
    import rom_pkg::*;

    logic              in_rom;
    logic [1:0]        word_ba;
    logic [addr_w-1:0] word_addr;
    logic              byte_we;

    // Region decode
    always_comb begin
        in_rom    = 1'b1;
        word_ba   = 2'd1;
        word_addr = '0;
        if (ioctl_addr < snd_start) begin
            // Main ROM goes to bank 0 from word 0
            word_ba   = 2'd0;
            word_addr = addr_w'(ioctl_addr >> 1);
        end else if (ioctl_addr < gfx_start) begin
            word_addr = addr_w'((ioctl_addr - snd_start) >> 1);
        end else if (ioctl_addr < rom_end) begin
            word_addr = gfx_base + addr_w'((ioctl_addr - gfx_start) >> 1);
        end else begin
            // Past the ROM, nothing to write
            in_rom = 1'b0;
        end
    end

    assign byte_we = ioctl_wr & downloading & in_rom;

    // Strobe and busy flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we    <= 1'b0;
            dwnld_busy <= 1'b0;
        end else begin
            prog_we    <= byte_we;
            dwnld_busy <= downloading;
        end
    end

    // Write payload, byte copied to both halves
    always_ff @(posedge clk) begin
        if (byte_we) begin
            prog.addr <= word_addr;
            prog.data <= {ioctl_data, ioctl_data};
            // Even byte enables the low half
            prog.mask <= {~ioctl_addr[0], ioctl_addr[0]};
            prog.ba   <= word_ba;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rom_read_slot.sv ====
/*
 * ROM read slot
 * Client cs/addr/data/ok port with a one-entry cache of a 32-bit word
 * pair; misses are fetched from bank 1 through the arbiter
 */
`default_nettype none

module rom_read_slot #(
    parameter type                           data_t    = logic [31:0],
    parameter int                             client_aw = 20,
    parameter logic [rom_pkg::addr_w-1:0]     base      = '0
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 flush,
    input  wire logic                 cs,
    input  wire logic [client_aw-1:0] addr,
    output data_t                     data,
    output logic                      ok,
    output rom_pkg::bank_req_t        req,
    input  wire logic                 ack,
    input  wire logic                 rdy,
    input  wire logic [31:0]          data_read
);
    import rom_pkg::*;

    localparam int dw      = $bits(data_t);
    localparam int byte_sh = $clog2(dw / 8);
    localparam int bw      = client_aw + byte_sh;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } slot_state_t;

    slot_state_t       state;
    logic [bw-1:0]     byte_addr;
    logic [addr_w-1:0] pair_addr;
    logic              hit;
    logic              ok_q;
    logic              rd_q;
    logic [addr_w-1:0] req_addr;
    logic              cache_valid;
    logic [addr_w-1:0] cache_addr;
    logic [31:0]       cache_data;

    // Client address as bytes, then as an aligned pair of SDRAM words
    assign byte_addr = bw'(addr) << byte_sh;
    assign pair_addr = base + (addr_w'(byte_addr[bw-1:2]) << 1);
    assign hit       = cache_valid && (cache_addr == pair_addr);

    // Low address bits pick the byte; always zero for 32-bit clients
    assign data = data_t'(cache_data >> {byte_addr[1:0], 3'b000});
    assign ok   = ok_q & cs & hit;
    assign req  = '{rd: rd_q, addr: req_addr};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            rd_q        <= 1'b0;
            ok_q        <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            ok_q <= cs & hit & ~flush;
            if (flush) begin
                cache_valid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (cs && !hit) begin
                        rd_q  <= 1'b1;
                        state <= st_req;
                    end
                end
                st_req: begin
                    // Hold rd until the bank takes it
                    if (ack) begin
                        rd_q  <= 1'b0;
                        state <= st_wait;
                    end
                end
                default: begin
                    if (rdy) begin
                        // Data fetched before a download ends is stale
                        cache_valid <= ~flush;
                        ok_q        <= cs & ~flush;
                        state       <= st_idle;
                    end
                end
            endcase
        end
    end

    // Request address and cached words
    always_ff @(posedge clk) begin
        if (state == st_idle && cs && !hit) begin
            req_addr <= pair_addr;
        end
        if (state == st_wait && rdy) begin
            cache_addr <= req_addr;
            cache_data <= data_read;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rom_subsys_top.sv ====
/*
 * ROM subsystem top level
 * Download packer, sound and graphics read slots and the bank 1
 * arbiter wired together
 */
`default_nettype none

module rom_subsys_top (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    // ROM download
    input  wire logic                         downloading,
    input  wire logic [rom_pkg::ioctl_aw-1:0] ioctl_addr,
    input  wire logic [7:0]                   ioctl_data,
    input  wire logic                         ioctl_wr,
    output logic                              dwnld_busy,
    output logic [rom_pkg::addr_w-1:0]        prog_addr,
    output logic [rom_pkg::data_w-1:0]        prog_data,
    output logic [1:0]                        prog_mask,
    output logic [1:0]                        prog_ba,
    output logic                              prog_we,
    // Sound CPU ROM
    input  wire logic                         snd_cs,
    input  wire logic [rom_pkg::snd_aw-1:0]   snd_addr,
    output logic [7:0]                        snd_data,
    output logic                              snd_ok,
    // Graphics ROM
    input  wire logic                         gfx_cs,
    input  wire logic [rom_pkg::gfx_aw-1:0]   gfx_addr,
    output logic [31:0]                       gfx_data,
    output logic                              gfx_ok,
    // Bank 1, read only
    output logic [rom_pkg::addr_w-1:0]        ba1_addr,
    output logic                              ba1_rd,
    input  wire logic                         ba1_ack,
    input  wire logic                         ba1_rdy,
    input  wire logic [31:0]                  data_read
);
    import rom_pkg::*;

    prog_word_t prog;
    bank_req_t  snd_req, gfx_req;
    logic       snd_ack, snd_rdy, gfx_ack, gfx_rdy;

    rom_prog_loader u_loader (
        .clk(clk), .arst_n(arst_n), .downloading(downloading),
        .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .prog(prog), .prog_we(prog_we), .dwnld_busy(dwnld_busy)
    );

    assign prog_addr = prog.addr;
    assign prog_data = prog.data;
    assign prog_mask = prog.mask;
    assign prog_ba   = prog.ba;

    // Sound bytes from bank 1 word 0
    rom_read_slot #(.data_t(logic [7:0]), .client_aw(snd_aw), .base('0)) u_snd_slot (
        .clk(clk), .arst_n(arst_n), .flush(downloading),
        .cs(snd_cs), .addr(snd_addr), .data(snd_data), .ok(snd_ok),
        .req(snd_req), .ack(snd_ack), .rdy(snd_rdy), .data_read(data_read)
    );

    rom_read_slot #(.data_t(logic [31:0]), .client_aw(gfx_aw), .base(gfx_base)) u_gfx_slot (
        .clk(clk), .arst_n(arst_n), .flush(downloading),
        .cs(gfx_cs), .addr(gfx_addr), .data(gfx_data), .ok(gfx_ok),
        .req(gfx_req), .ack(gfx_ack), .rdy(gfx_rdy), .data_read(data_read)
    );

    rom_bank_arbiter u_arbiter (
        .clk(clk), .arst_n(arst_n), .downloading(downloading),
        .req_a(snd_req), .req_b(gfx_req),
        .ack_a(snd_ack), .ack_b(gfx_ack), .rdy_a(snd_rdy), .rdy_b(gfx_rdy),
        .ba_addr(ba1_addr), .ba_rd(ba1_rd), .ba_ack(ba1_ack), .ba_rdy(ba1_rdy)
    );

endmodule

`default_nettype wire

// ==== verification/rom_cases.txt ====
# L ioctl_addr byte exp_ba exp_word_addr exp_mask (mask 3: past ROM end, no write)
# S|G addr exp_data rd_count / R exp_data rd_count / B sa sd ga gd rd_count / D ioa byte sa sd rd
L 000010 11 0 000008 2
L 000011 22 0 000008 1
L 040000 a1 1 000000 2
L 040001 b2 1 000000 1
L 040002 c3 1 000001 2
L 040003 d4 1 000001 1
L 060010 01 1 010008 2
L 060011 23 1 010008 1
L 060012 45 1 010009 2
L 060013 67 1 010009 1
L 460000 ee 0 000000 3
L 45ffff 99 1 20ffff 1
S 00002 c3 1
R c3 0
S 00003 d4 0
G 00004 67452301 1
R 67452301 0
L 040005 5e 1 000002 1
L 060020 89 1 010010 2
L 060021 ab 1 010010 1
L 060022 cd 1 010011 2
L 060023 ef 1 010011 1
B 00005 5e 00008 efcdab89 2
D 040005 77 00005 77 1
G 00008 efcdab89 1
S 00000 a1 1

// ==== verification/rom_subsys_sva.sv ====
/*
 * Bank 1 protocol and programming strobe checks
 * One checker, bound into the arbiter and into the loader
 */
`default_nettype none

module rom_subsys_sva (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic downloading,
    input wire logic ba_rd,
    input wire logic ba_ack,
    input wire logic prog_we
);

    // Read request stays up until the bank has acknowledged it
    rd_held: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ba_rd) |-> $past(ba_ack))
        else $error("ba1_rd fell without a preceding ba1_ack");

    ack_with_rd: assert property (@(posedge clk) disable iff (!arst_n)
        ba_ack |-> ba_rd)
        else $error("ba1_ack seen with no ba1_rd pending");

    // A grant taken during a download would start a bank read
    no_rd_in_download: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ba_rd) |-> !$past(downloading))
        else $error("ba1_rd raised while downloading");

    prog_we_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |=> !prog_we)
        else $error("prog_we held longer than one cycle");

endmodule

bind rom_bank_arbiter rom_subsys_sva u_arb_sva (
    .clk(clk), .arst_n(arst_n), .downloading(downloading),
    .ba_rd(ba_rd), .ba_ack(ba_ack), .prog_we(1'b0)
);

bind rom_prog_loader rom_subsys_sva u_loader_sva (
    .clk(clk), .arst_n(arst_n), .downloading(downloading),
    .ba_rd(1'b0), .ba_ack(1'b0), .prog_we(prog_we)
);

`default_nettype wire

// ==== verification/rom_subsys_tb.sv ====
/*
 * ROM subsystem testbench
 * Runs download and read cases from a text file against a bank 1
 * SDRAM model with random ack and data delays
 */
`default_nettype none

module rom_subsys_tb;
    import rom_pkg::*;

    localparam int prog_timeout = 8;
    localparam int read_timeout = 120;

    logic                clk;
    logic                arst_n;
    logic                downloading;
    logic [ioctl_aw-1:0] ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    logic                dwnld_busy;
    logic [addr_w-1:0]   prog_addr;
    logic [data_w-1:0]   prog_data;
    logic [1:0]          prog_mask;
    logic [1:0]          prog_ba;
    logic                prog_we;
    logic                snd_cs;
    logic [snd_aw-1:0]   snd_addr;
    logic [7:0]          snd_data;
    logic                snd_ok;
    logic                gfx_cs;
    logic [gfx_aw-1:0]   gfx_addr;
    logic [31:0]         gfx_data;
    logic                gfx_ok;
    logic [addr_w-1:0]   ba1_addr;
    logic                ba1_rd;
    logic                ba1_ack   = 1'b0;
    logic                ba1_rdy   = 1'b0;
    logic [31:0]         data_read = '0;

    integer      seed = 90636;
    int          errors;
    int          case_no;
    int          rd_count;
    logic        rd_prev;
    logic [15:0] bank1 [int];

    rom_subsys_top u_rom_subsys_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Unwritten words read back as a pattern of their address
    function automatic logic [15:0] read_word(input logic [addr_w-1:0] a);
        if (bank1.exists(int'(a))) begin
            return bank1[int'(a)];
        end
        return 16'(a) ^ 16'(a >> 8) ^ 16'h5a3c;
    endfunction

    // Bank 1 programming, active low byte mask
    always @(posedge clk) begin : bank1_write
        logic [15:0] w;
        if (prog_we && prog_ba == 2'd1) begin
            w = read_word(prog_addr);
            if (!prog_mask[0]) w[7:0] = prog_data[7:0];
            if (!prog_mask[1]) w[15:8] = prog_data[15:8];
            bank1[int'(prog_addr)] = w;
        end
    end

    // Bank 1 read port: ack after 1 to 4 cycles, data 1 to 6 later
    always begin : bank1_read
        logic [addr_w-1:0] a;
        int                dly;
        @(posedge clk);
        if (arst_n && ba1_rd) begin
            a   = ba1_addr;
            dly = 1 + int'({$random(seed)} % 4);
            repeat (dly - 1) @(posedge clk);
            ba1_ack <= 1'b1;
            @(posedge clk);
            ba1_ack <= 1'b0;
            dly = 1 + int'({$random(seed)} % 6);
            repeat (dly - 1) @(posedge clk);
            data_read <= {read_word(a + addr_w'(1)), read_word(a)};
            ba1_rdy   <= 1'b1;
            @(posedge clk);
            ba1_rdy   <= 1'b0;
        end
    end

    // Counts bank requests
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_count <= 0;
            rd_prev  <= 1'b0;
        end else begin
            if (ba1_rd && !rd_prev) rd_count <= rd_count + 1;
            rd_prev <= ba1_rd;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] case %0d %s got 0x%h expected 0x%h", case_no, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("case %0d: %s", case_no, msg);
            errors++;
        end
    endtask

    task automatic write_byte(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        ioctl_addr <= ioctl_aw'(addr);
        ioctl_data <= 8'(data);
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
    endtask

    task automatic wait_prog(output logic found, output prog_word_t seen);
        found = 1'b0;
        seen  = '0;
        for (int cyc = 0; cyc < prog_timeout && !found; cyc++) begin
            @(negedge clk);
            if (prog_we) begin
                found = 1'b1;
                seen  = '{addr: prog_addr, data: prog_data, mask: prog_mask, ba: prog_ba};
            end
        end
    endtask

    task automatic load_op(input logic [31:0] addr, data, ba, waddr, mask);
        logic       found;
        prog_word_t seen;
        @(posedge clk);
        downloading <= 1'b1;
        write_byte(addr, data);
        wait_prog(found, seen);
        if (mask == 32'h3) begin
            expect_true(!found, "prog_we raised for a byte past the ROM end");
        end else begin
            expect_true(found, "no prog_we within the timeout");
            if (found) begin
                compare_value("prog_ba", 32'(seen.ba), ba);
                compare_value("prog_addr", 32'(seen.addr), waddr);
                compare_value("prog_mask", 32'(seen.mask), mask);
                compare_value("prog_data", 32'(seen.data), {16'h0, data[7:0], data[7:0]});
            end
        end
        compare_value("dwnld_busy", 32'(dwnld_busy), 32'h1);
        @(posedge clk);
        downloading <= 1'b0;
        // Busy trails downloading by one register
        @(negedge clk);
        compare_value("dwnld_busy", 32'(dwnld_busy), 32'h1);
        @(negedge clk);
        compare_value("dwnld_busy", 32'(dwnld_busy), 32'h0);
    endtask

    // Optional download of one byte while the read is pending
    task automatic read_op(input logic snd_en, gfx_en, dl_en,
                           input logic [31:0] sa, se, ga, ge, ioa, nb, input int exp_rd);
        int          rd_base;
        logic        snd_done;
        logic        gfx_done;
        logic        found;
        prog_word_t  seen;
        logic [7:0]  snd_got;
        logic [31:0] gfx_got;
        rd_base  = rd_count;
        snd_done = !snd_en;
        gfx_done = !gfx_en;
        snd_got  = '0;
        gfx_got  = '0;
        if (dl_en) begin
            @(posedge clk);
            downloading <= 1'b1;
        end
        @(posedge clk);
        snd_cs   <= snd_en;
        snd_addr <= snd_aw'(sa);
        gfx_cs   <= gfx_en;
        gfx_addr <= gfx_aw'(ga);
        if (dl_en) begin
            write_byte(ioa, nb);
            wait_prog(found, seen);
            expect_true(found, "no prog_we for the byte loaded during the read");
            compare_value("ba1_rd count in download", 32'(rd_count - rd_base), 32'h0);
            @(posedge clk);
            downloading <= 1'b0;
        end
        for (int cyc = 0; cyc < read_timeout && !(snd_done && gfx_done); cyc++) begin
            @(negedge clk);
            if (!snd_done && snd_ok) begin
                snd_done = 1'b1;
                snd_got  = snd_data;
            end
            if (!gfx_done && gfx_ok) begin
                gfx_done = 1'b1;
                gfx_got  = gfx_data;
            end
        end
        @(posedge clk);
        snd_cs <= 1'b0;
        gfx_cs <= 1'b0;
        expect_true(snd_done, "timed out waiting for snd_ok");
        expect_true(gfx_done, "timed out waiting for gfx_ok");
        if (snd_en && snd_done) compare_value("snd_data", 32'(snd_got), se);
        if (gfx_en && gfx_done) compare_value("gfx_data", gfx_got, ge);
        compare_value("ba1_rd count", 32'(rd_count - rd_base), 32'(exp_rd));
    endtask

    initial begin
        int          fd;
        int          n;
        int          failed;
        int          err_base;
        string       line;
        logic [7:0]  op;
        logic [31:0] f0, f1, f2, f3, f4;
        logic [7:0]  last_op;
        logic [31:0] last_addr;
        errors      = 0;
        case_no     = 0;
        failed      = 0;
        last_op     = "S";
        last_addr   = '0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("verification/rom_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h %h", op, f0, f1, f2, f3, f4);
                    case_no++;
                    err_base = errors;
                    case (op)
                        "L": load_op(f0, f1, f2, f3, f4);
                        "S", "G": begin
                            read_op(op == "S", op == "G", 1'b0, f0, f1, f0, f1,
                                    32'h0, 32'h0, int'(f2));
                            last_op   = op;
                            last_addr = f0;
                        end
                        "R": read_op(last_op == "S", last_op == "G", 1'b0, last_addr, f0,
                                     last_addr, f0, 32'h0, 32'h0, int'(f1));
                        "B": read_op(1'b1, 1'b1, 1'b0, f0, f1, f2, f3, 32'h0, 32'h0, int'(f4));
                        "D": read_op(1'b1, 1'b0, 1'b1, f2, f3, 32'h0, 32'h0, f0, f1, int'(f4));
                        default: expect_true(1'b0, "unknown operation in the case file");
                    endcase
                    if (errors != err_base) failed++;
                    $display("case %0d %c: %s", case_no, op, (errors == err_base) ? "pass" : "FAIL");
                end
            end
            $fclose(fd);
        end
        repeat (4) @(posedge clk);
        $display("cases %0d, failed %0d, errors %0d", case_no, failed, errors);
        if (errors == 0 && case_no > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
